//--- hw/cfg_consts.svh
// Configuration subsystem constants
`ifndef CFG_CONSTS_SVH
`define CFG_CONSTS_SVH

// ====================
// Bus widths
// ====================
// Byte address on the configuration bus
`define CFG_ADDR_W 12
// Data path width
`define CFG_DATA_W 32

// ====================
// Register blocks
// ====================
// Event inputs into STATUS
`define CFG_EVENT_W 8
// Scratch bank depth
`define CFG_SCRATCH_N 4
// Fixed ID register value
`define CFG_ID_VALUE 32'hC0F1_0001
// Read value for unmapped space
`define CFG_UNMAPPED_DATA 32'hDEAD_BEEF

`endif

//--- hw/cfg_pkg.sv
// Configuration subsystem types
`default_nettype none

`include "cfg_consts.svh"

package cfg_pkg;

   // ====================
   // Bus payload types
   // ====================
   // Configuration byte address
   typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
   // One data word
   typedef logic [`CFG_DATA_W-1:0] cfg_data_t;

   // ====================
   // Enumerations
   // ====================
   // AXI-Lite converter states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      ADDR  = 2'd1,
      WDATA = 2'd2,
      RESP  = 2'd3
   } axil_state_e;

   // Decoder target select
   typedef enum logic [1:0] {
      TGT_SCRATCH = 2'd0,
      TGT_EVENT   = 2'd1,
      TGT_NONE    = 2'd2
   } cfg_target_e;

endpackage

`default_nettype wire

//--- hw/cfg_bus_if.sv
// Configuration bus interface
`timescale 1ns/10ps
`default_nettype none

interface cfg_bus_if;
   import cfg_pkg::*;

   // Request side, held by the master until ack
   cfg_addr_t addr;
   cfg_data_t wdata;
   logic      wr;
   logic      rd;

   // Response side, ack is a single-cycle pulse
   cfg_data_t rdata;
   logic      ack;

   // Requester view
   modport master (
      output addr,
      output wdata,
      output wr,
      output rd,
      input  ack,
      input  rdata
   );

   // Responder view
   modport slave (
      input  addr,
      input  wdata,
      input  wr,
      input  rd,
      output ack,
      output rdata
   );

endinterface

`default_nettype wire

//--- hw/axil_to_cfg.sv
// AXI-Lite to configuration bus converter
`timescale 1ns/10ps
`default_nettype none

module axil_to_cfg (
   input  wire                     clk,
   input  wire                     rst_n,
   // Write address channel
   input  wire                     awvalid,
   output logic                    awready,
   input  wire cfg_pkg::cfg_addr_t awaddr,
   // Write data channel
   input  wire                     wvalid,
   output logic                    wready,
   input  wire cfg_pkg::cfg_data_t wdata,
   // Write response channel
   output logic                    bvalid,
   input  wire                     bready,
   output logic [1:0]              bresp,
   // Read address channel
   input  wire                     arvalid,
   output logic                    arready,
   input  wire cfg_pkg::cfg_addr_t araddr,
   // Read data channel
   output logic                    rvalid,
   input  wire                     rready,
   output cfg_pkg::cfg_data_t      rdata,
   output logic [1:0]              rresp,
   // Configuration bus toward the decoder
   cfg_bus_if.master               cfg,
   output logic                    busy
);
   import cfg_pkg::*;

   axil_state_e state_q;
   axil_state_e state_nxt;
   // Direction of the captured access, 1 for write
   logic        is_wr_q;
   cfg_addr_t   addr_q;
   logic        wr_q;
   logic        rd_q;
   cfg_data_t   rdata_q;
   logic        wr_done;
   logic        rd_done;

   // Strobe completion
   assign wr_done = wr_q && cfg.ack;
   assign rd_done = rd_q && cfg.ack;

   // ====================
   // State machine
   // ====================
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         IDLE: begin
            if (awvalid || arvalid) begin
               state_nxt = ADDR;
            end
         end
         // Reads go straight to RESP and wait there for the data
         ADDR: state_nxt = is_wr_q ? WDATA : RESP;
         WDATA: begin
            if (wr_done) begin
               state_nxt = RESP;
            end
         end
         RESP: begin
            if ((bvalid && bready) || (rvalid && rready)) begin
               state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   // Any access in flight or starting
   assign busy = (state_nxt != IDLE);

   // ====================
   // Address capture
   // ====================
   // Write address wins when both are valid
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         is_wr_q <= 1'b0;
      end else if (state_q == IDLE && awvalid) begin
         is_wr_q <= 1'b1;
      end else if (state_q == IDLE && arvalid) begin
         is_wr_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == IDLE) begin
         addr_q <= awvalid ? awaddr : araddr;
      end
   end

   // One-cycle address ready pulses
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         awready <= 1'b0;
         arready <= 1'b0;
      end else begin
         awready <= (state_q == IDLE) && awvalid;
         arready <= (state_q == IDLE) && arvalid && !awvalid;
      end
   end

   // ====================
   // Config strobes
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         // Write strobe waits for write data
         if (state_nxt == WDATA && wvalid) begin
            wr_q <= 1'b1;
         end else if (wr_done) begin
            wr_q <= 1'b0;
         end
         if (state_q == ADDR && !is_wr_q) begin
            rd_q <= 1'b1;
         end else if (rd_done) begin
            rd_q <= 1'b0;
         end
      end
   end

   assign cfg.addr  = addr_q;
   // Write data is held by the master until wready
   assign cfg.wdata = wdata;
   assign cfg.wr    = wr_q;
   assign cfg.rd    = rd_q;

   // ====================
   // AXI responses
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wready <= 1'b0;
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         wready <= wr_done;
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end else if (wready && wvalid) begin
            bvalid <= 1'b1;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end else if (rd_done) begin
            rvalid <= 1'b1;
         end
      end
   end

   // Read data captured with ack
   always_ff @(posedge clk) begin
      if (rd_done) begin
         rdata_q <= cfg.rdata;
      end
   end

   assign rdata = rdata_q;
   // Always OKAY
   assign bresp = 2'b00;
   assign rresp = 2'b00;

   // Strobes are exclusive on the config bus
   assert property (@(posedge clk) disable iff (!rst_n) !(cfg.wr && cfg.rd));

   // Responses hold under back-pressure and block new addresses
   assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && !awready && !arready);
   assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && !awready && !arready);

endmodule

`default_nettype wire

//--- hw/cfg_addr_decode.sv
// Configuration address decoder
`timescale 1ns/10ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_addr_decode (
   input  wire       clk,
   input  wire       rst_n,
   cfg_bus_if.slave  up,
   cfg_bus_if.master scratch,
   cfg_bus_if.master evt
);
   import cfg_pkg::*;

   cfg_target_e tgt;
   // Local responder for unmapped space
   logic        none_ack_q;
   logic        none_req;

   // ====================
   // Target select
   // ====================
   always_comb begin
      if (|up.addr[`CFG_ADDR_W-1:7]) begin
         tgt = TGT_NONE;
      end else if (up.addr[6]) begin
         tgt = TGT_EVENT;
      end else begin
         tgt = TGT_SCRATCH;
      end
   end

   // Address and data fan out, strobes only to the selected target
   assign scratch.addr  = up.addr;
   assign scratch.wdata = up.wdata;
   assign scratch.wr    = up.wr && (tgt == TGT_SCRATCH);
   assign scratch.rd    = up.rd && (tgt == TGT_SCRATCH);
   assign evt.addr      = up.addr;
   assign evt.wdata     = up.wdata;
   assign evt.wr        = up.wr && (tgt == TGT_EVENT);
   assign evt.rd        = up.rd && (tgt == TGT_EVENT);

   // Unmapped writes are dropped, only acked
   assign none_req = (up.wr || up.rd) && (tgt == TGT_NONE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= none_req && !none_ack_q;
      end
   end

   // ====================
   // Response merge
   // ====================
   assign up.ack = scratch.ack || evt.ack || none_ack_q;

   always_comb begin
      case (tgt)
         TGT_SCRATCH: up.rdata = scratch.rdata;
         TGT_EVENT:   up.rdata = evt.rdata;
         default:     up.rdata = `CFG_UNMAPPED_DATA;
      endcase
   end

   // Only the selected target ever answers
   assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({scratch.ack, evt.ack, none_ack_q}));

endmodule

`default_nettype wire

//--- hw/cfg_scratch_regs.sv
// Scratch register bank
`timescale 1ns/10ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_scratch_regs (
   input  wire      clk,
   input  wire      rst_n,
   cfg_bus_if.slave bus
);
   import cfg_pkg::*;

   localparam int IDX_W = $clog2(`CFG_SCRATCH_N);

   cfg_data_t  regs_q [`CFG_SCRATCH_N];
   logic       ack_q;
   logic [3:0] idx;
   logic       in_bank;

   // Word index within the block
   assign idx     = bus.addr[5:2];
   assign in_bank = (idx < `CFG_SCRATCH_N);

   // ====================
   // Ack and write
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
         for (int i = 0; i < `CFG_SCRATCH_N; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         // First strobe cycle only
         ack_q <= (bus.wr || bus.rd) && !ack_q;
         if (bus.wr && !ack_q && in_bank) begin
            regs_q[idx[IDX_W-1:0]] <= bus.wdata;
         end
      end
   end

   assign bus.ack   = ack_q;
   // Out-of-bank indices read zero
   assign bus.rdata = in_bank ? regs_q[idx[IDX_W-1:0]] : '0;

   // Ack only while a strobe is held
   assert property (@(posedge clk) disable iff (!rst_n) bus.ack |-> (bus.wr || bus.rd));

endmodule

`default_nettype wire

//--- hw/cfg_event_status.sv
// Event status and interrupt block
`timescale 1ns/10ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_event_status (
   input  wire                   clk,
   input  wire                   rst_n,
   cfg_bus_if.slave              bus,
   input  wire [`CFG_EVENT_W-1:0] event_in,
   output logic                  irq
);
   import cfg_pkg::*;

   // Register word indices
   localparam logic [3:0] IDX_STATUS = 4'd0;
   localparam logic [3:0] IDX_MASK   = 4'd1;
   localparam logic [3:0] IDX_ID     = 4'd2;

   logic [`CFG_EVENT_W-1:0] status_q;
   logic [`CFG_EVENT_W-1:0] mask_q;
   logic [`CFG_EVENT_W-1:0] clr;
   logic                    ack_q;
   logic                    wr_fire;
   logic [3:0]              idx;

   assign idx     = bus.addr[5:2];
   assign wr_fire = bus.wr && !ack_q;
   // Write-one-to-clear bits
   assign clr     = (wr_fire && idx == IDX_STATUS) ? bus.wdata[`CFG_EVENT_W-1:0] : '0;

   // ====================
   // Registers
   // ====================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack_q    <= 1'b0;
         status_q <= '0;
         mask_q   <= '0;
         irq      <= 1'b0;
      end else begin
         ack_q    <= (bus.wr || bus.rd) && !ack_q;
         // New events win over a same-cycle clear
         status_q <= (status_q & ~clr) | event_in;
         if (wr_fire && idx == IDX_MASK) begin
            mask_q <= bus.wdata[`CFG_EVENT_W-1:0];
         end
         irq      <= |(status_q & mask_q);
      end
   end

   assign bus.ack = ack_q;

   // Read mux, unused indices read zero
   always_comb begin
      case (idx)
         IDX_STATUS: bus.rdata = cfg_data_t'(status_q);
         IDX_MASK:   bus.rdata = cfg_data_t'(mask_q);
         IDX_ID:     bus.rdata = `CFG_ID_VALUE;
         default:    bus.rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/cfg_subsys_top.sv
// Configuration subsystem top level
`timescale 1ns/10ps
`default_nettype none

`include "cfg_consts.svh"

module cfg_subsys_top (
   input  wire                    clk,
   input  wire                    rst_n,
   // AXI-Lite slave port
   input  wire                    awvalid,
   output logic                   awready,
   input  wire [31:0]             awaddr,
   input  wire                    wvalid,
   output logic                   wready,
   input  wire [`CFG_DATA_W-1:0]  wdata,
   output logic                   bvalid,
   input  wire                    bready,
   output logic [1:0]             bresp,
   input  wire                    arvalid,
   output logic                   arready,
   input  wire [31:0]             araddr,
   output logic                   rvalid,
   input  wire                    rready,
   output logic [`CFG_DATA_W-1:0] rdata,
   output logic [1:0]             rresp,
   // Events and status
   input  wire [`CFG_EVENT_W-1:0] event_in,
   output logic                   irq,
   output logic                   busy
);

   // One bus per link
   cfg_bus_if up_bus ();
   cfg_bus_if scratch_bus ();
   cfg_bus_if event_bus ();

   // ====================
   // Converter
   // ====================
   // Upper address bits are outside the config space
   axil_to_cfg u_axil_to_cfg (
      .clk     (clk),
      .rst_n   (rst_n),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr[`CFG_ADDR_W-1:0]),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr[`CFG_ADDR_W-1:0]),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp),
      .cfg     (up_bus.master),
      .busy    (busy)
   );

   // ====================
   // Decode and targets
   // ====================
   cfg_addr_decode u_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .up      (up_bus.slave),
      .scratch (scratch_bus.master),
      .evt     (event_bus.master)
   );

   cfg_scratch_regs u_scratch (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (scratch_bus.slave)
   );

   cfg_event_status u_event (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (event_bus.slave),
      .event_in (event_in),
      .irq      (irq)
   );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
// Testbench clock source
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS = 100
) (
   output logic clk
);

   // Free-running, starts low
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

//--- verif/tb_cfg_subsys.sv
// Configuration subsystem testbench
`timescale 1ns/10ps
`default_nettype none

`include "cfg_consts.svh"

module tb_cfg_subsys;
   import cfg_pkg::*;

   localparam int TIMEOUT_CYCLES = 64;
   localparam int SIDX_W         = $clog2(`CFG_SCRATCH_N);
   // Handshake flags that the transfer tasks wait on
   localparam int SEL_AWREADY    = 0;
   localparam int SEL_WREADY     = 1;
   localparam int SEL_BVALID     = 2;
   localparam int SEL_ARREADY    = 3;
   localparam int SEL_RVALID     = 4;

   logic                    clk;
   logic                    rst_n;
   logic                    awvalid;
   logic                    awready;
   logic [31:0]             awaddr;
   logic                    wvalid;
   logic                    wready;
   logic [`CFG_DATA_W-1:0]  wdata;
   logic                    bvalid;
   logic                    bready;
   logic [1:0]              bresp;
   logic                    arvalid;
   logic                    arready;
   logic [31:0]             araddr;
   logic                    rvalid;
   logic                    rready;
   logic [`CFG_DATA_W-1:0]  rdata;
   logic [1:0]              rresp;
   logic [`CFG_EVENT_W-1:0] event_in;
   logic                    irq;
   logic                    busy;

   // Reference model state
   cfg_data_t               model_scratch [`CFG_SCRATCH_N];
   logic [`CFG_EVENT_W-1:0] model_status;
   logic [`CFG_EVENT_W-1:0] model_mask;

   tb_clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk(clk));

   cfg_subsys_top UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .awvalid  (awvalid),
      .awready  (awready),
      .awaddr   (awaddr),
      .wvalid   (wvalid),
      .wready   (wready),
      .wdata    (wdata),
      .bvalid   (bvalid),
      .bready   (bready),
      .bresp    (bresp),
      .arvalid  (arvalid),
      .arready  (arready),
      .araddr   (araddr),
      .rvalid   (rvalid),
      .rready   (rready),
      .rdata    (rdata),
      .rresp    (rresp),
      .event_in (event_in),
      .irq      (irq),
      .busy     (busy)
   );

   // ====================
   // Error reporting
   // ====================
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   // ====================
   // Reference model
   // ====================
   // Address map: bits above 6 unmapped, bit 6 picks block, 5:2 index
   function automatic cfg_data_t expected_read(input logic [31:0] addr);
      logic [`CFG_ADDR_W-1:0] a;
      logic [3:0]             idx;
      cfg_data_t              val;
      a   = addr[`CFG_ADDR_W-1:0];
      idx = a[5:2];
      val = '0;
      if (|a[`CFG_ADDR_W-1:7]) begin
         val = `CFG_UNMAPPED_DATA;
      end else if (!a[6]) begin
         if (idx < `CFG_SCRATCH_N) begin
            val = model_scratch[idx[SIDX_W-1:0]];
         end
      end else if (idx == 4'd0) begin
         val = cfg_data_t'(model_status);
      end else if (idx == 4'd1) begin
         val = cfg_data_t'(model_mask);
      end else if (idx == 4'd2) begin
         val = `CFG_ID_VALUE;
      end
      return val;
   endfunction

   task automatic model_write(input logic [31:0] addr, input cfg_data_t data);
      logic [`CFG_ADDR_W-1:0] a;
      logic [3:0]             idx;
      a   = addr[`CFG_ADDR_W-1:0];
      idx = a[5:2];
      // Unmapped writes fall through untouched
      if (!(|a[`CFG_ADDR_W-1:7])) begin
         if (!a[6] && idx < `CFG_SCRATCH_N) begin
            model_scratch[idx[SIDX_W-1:0]] = data;
         end else if (a[6] && idx == 4'd0) begin
            model_status = model_status & ~data[`CFG_EVENT_W-1:0];
         end else if (a[6] && idx == 4'd1) begin
            model_mask = data[`CFG_EVENT_W-1:0];
         end
      end
   endtask

   task automatic check_irq();
      check_bit("irq", irq, |(model_status & model_mask));
   endtask

   // ====================
   // Stimulus helpers
   // ====================
   // Bits 1:0 random, they are ignored by the map
   function automatic logic [31:0] make_addr(input logic blk, input logic [3:0] idx);
      logic [31:0] low;
      low = $urandom();
      return {25'b0, blk, idx, low[1:0]};
   endfunction

   function automatic logic [31:0] make_unmapped_addr();
      logic [31:0] r;
      r = $urandom();
      if (r[11:7] == 5'b0) begin
         r[11] = 1'b1;
      end
      return {20'b0, r[11:0]};
   endfunction

   // Sparse event pattern
   function automatic logic [`CFG_EVENT_W-1:0] rand_events();
      logic [31:0] r1;
      logic [31:0] r2;
      r1 = $urandom();
      r2 = $urandom();
      r1 = r1 & r2;
      return r1[`CFG_EVENT_W-1:0];
   endfunction

   function automatic logic chan_flag(input int sel);
      case (sel)
         SEL_AWREADY: return awready;
         SEL_WREADY:  return wready;
         SEL_BVALID:  return bvalid;
         SEL_ARREADY: return arready;
         default:     return rvalid;
      endcase
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // Sampled on the falling edge, away from the DUT updates
   task automatic wait_flag(input int sel, input string name);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!chan_flag(sel)) begin
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("no %s from the DUT within %0d cycles", name, TIMEOUT_CYCLES));
         end else begin
            @(negedge clk);
         end
      end
   endtask

   // ====================
   // AXI-Lite transfers
   // ====================
   task automatic finish_write(input logic busy_exp);
      int hold;
      hold = $urandom_range(0, 5);
      wait_flag(SEL_BVALID, "bvalid");
      check_bit("rvalid", rvalid, 1'b0);
      check_resp("bresp", bresp, 2'b00);
      // Back-pressure, bvalid must hold
      repeat (hold) begin
         @(negedge clk);
         check_bit("bvalid", bvalid, 1'b1);
      end
      @(posedge clk);
      bready <= 1'b1;
      @(posedge clk);
      bready <= 1'b0;
      @(negedge clk);
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("busy", busy, busy_exp);
   endtask

   task automatic finish_read(output cfg_data_t data, input logic busy_exp);
      int hold;
      hold = $urandom_range(0, 5);
      wait_flag(SEL_RVALID, "rvalid");
      check_bit("bvalid", bvalid, 1'b0);
      check_resp("rresp", rresp, 2'b00);
      data = rdata;
      repeat (hold) begin
         @(negedge clk);
         check_bit("rvalid", rvalid, 1'b1);
         check_data("rdata held", rdata, data);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
      @(negedge clk);
      check_bit("rvalid", rvalid, 1'b0);
      check_bit("busy", busy, busy_exp);
   endtask

   task automatic axil_write(input logic [31:0] addr, input cfg_data_t data);
      int gap;
      gap = $urandom_range(0, 3);
      idle_cycles($urandom_range(0, 3));
      @(posedge clk);
      awvalid <= 1'b1;
      awaddr  <= addr;
      wdata   <= data;
      // No gap means write data comes along with the address
      if (gap == 0) begin
         wvalid <= 1'b1;
      end
      wait_flag(SEL_AWREADY, "awready");
      @(posedge clk);
      awvalid <= 1'b0;
      if (gap != 0) begin
         idle_cycles(gap - 1);
         wvalid <= 1'b1;
      end
      wait_flag(SEL_WREADY, "wready");
      @(posedge clk);
      wvalid <= 1'b0;
      finish_write(1'b0);
      model_write(addr, data);
   endtask

   task automatic axil_read(input logic [31:0] addr, output cfg_data_t data);
      idle_cycles($urandom_range(0, 3));
      @(posedge clk);
      arvalid <= 1'b1;
      araddr  <= addr;
      wait_flag(SEL_ARREADY, "arready");
      @(posedge clk);
      arvalid <= 1'b0;
      finish_read(data, 1'b0);
   endtask

   task automatic read_check(input logic [31:0] addr);
      cfg_data_t got;
      axil_read(addr, got);
      check_data($sformatf("rdata[0x%03h]", addr[11:0]), got, expected_read(addr));
   endtask

   task automatic read_all_mapped();
      for (int k = 0; k < `CFG_SCRATCH_N; k++) begin
         read_check(make_addr(1'b0, 4'(k)));
      end
      read_check(make_addr(1'b1, 4'd0));
      read_check(make_addr(1'b1, 4'd1));
      read_check(make_addr(1'b1, 4'd2));
   endtask

   // Both address channels valid in one cycle, write must go first
   task automatic write_then_read(input logic [31:0] addr, input cfg_data_t data);
      cfg_data_t got;
      @(posedge clk);
      awvalid <= 1'b1;
      arvalid <= 1'b1;
      awaddr  <= addr;
      araddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      wait_flag(SEL_AWREADY, "awready");
      check_bit("arready", arready, 1'b0);
      @(posedge clk);
      awvalid <= 1'b0;
      wait_flag(SEL_WREADY, "wready");
      @(posedge clk);
      wvalid <= 1'b0;
      // Pending read keeps the converter busy
      finish_write(1'b1);
      model_write(addr, data);
      wait_flag(SEL_ARREADY, "arready");
      @(posedge clk);
      arvalid <= 1'b0;
      finish_read(got, 1'b0);
      check_data($sformatf("rdata[0x%03h]", addr[11:0]), got, expected_read(addr));
   endtask

   // One-cycle pulse, then irq gets one edge to follow
   task automatic pulse_events(input logic [`CFG_EVENT_W-1:0] bits);
      @(posedge clk);
      event_in <= bits;
      @(posedge clk);
      event_in <= '0;
      model_status = model_status | bits;
      @(posedge clk);
      @(negedge clk);
      check_irq();
   endtask

   // ====================
   // Main sequence
   // ====================
   initial begin : main_seq
      cfg_data_t d;
      void'($urandom(24));
      rst_n    <= 1'b0;
      awvalid  <= 1'b0;
      awaddr   <= '0;
      wvalid   <= 1'b0;
      wdata    <= '0;
      bready   <= 1'b0;
      arvalid  <= 1'b0;
      araddr   <= '0;
      rready   <= 1'b0;
      event_in <= '0;
      for (int k = 0; k < `CFG_SCRATCH_N; k++) begin
         model_scratch[k] = '0;
      end
      model_status = '0;
      model_mask   = '0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("awready", awready, 1'b0);
      check_bit("arready", arready, 1'b0);
      check_bit("wready", wready, 1'b0);
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("rvalid", rvalid, 1'b0);
      check_bit("irq", irq, 1'b0);
      check_bit("busy", busy, 1'b0);

      // Scratch bank, indices past the bank included
      for (int k = 0; k < 24; k++) begin
         d = $urandom();
         axil_write(make_addr(1'b0, 4'($urandom_range(0, 15))), d);
         if (k % 3 == 0) begin
            read_check(make_addr(1'b0, 4'($urandom_range(0, 15))));
         end
      end
      for (int k = 0; k < 16; k++) begin
         read_check(make_addr(1'b0, 4'(k)));
      end

      // ID, reserved event indices, unmapped space
      axil_write(make_addr(1'b1, 4'd2), $urandom());
      read_check(make_addr(1'b1, 4'd2));
      for (int k = 3; k < 16; k += 4) begin
         read_check(make_addr(1'b1, 4'(k)));
      end
      for (int k = 0; k < 6; k++) begin
         read_check(make_unmapped_addr());
         axil_write(make_unmapped_addr(), $urandom());
      end
      read_all_mapped();

      // Sticky status and write-one clear
      for (int k = 0; k < 6; k++) begin
         repeat (3) pulse_events(rand_events());
         read_check(make_addr(1'b1, 4'd0));
         axil_write(make_addr(1'b1, 4'd0), $urandom());
         read_check(make_addr(1'b1, 4'd0));
         check_irq();
      end

      // Mask and interrupt
      for (int k = 0; k < 8; k++) begin
         axil_write(make_addr(1'b1, 4'd1), $urandom());
         check_irq();
         pulse_events(rand_events());
         axil_write(make_addr(1'b1, 4'd0), $urandom());
         check_irq();
         read_check(make_addr(1'b1, 4'd1));
      end
      axil_write(make_addr(1'b1, 4'd1), 32'h0000_00FF);
      pulse_events('1);
      check_irq();
      axil_write(make_addr(1'b1, 4'd0), 32'hFFFF_FFFF);
      check_irq();

      // Same-cycle write and read
      for (int k = 0; k < 6; k++) begin
         d = $urandom();
         write_then_read(make_addr(1'b0, 4'($urandom_range(0, `CFG_SCRATCH_N - 1))), d);
      end
      read_all_mapped();

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- cfg_subsys_top.f
+incdir+hw
hw/cfg_pkg.sv
hw/cfg_bus_if.sv
hw/axil_to_cfg.sv
hw/cfg_addr_decode.sv
hw/cfg_scratch_regs.sv
hw/cfg_event_status.sv
hw/cfg_subsys_top.sv
verif/tb_clk_gen.sv
verif/tb_cfg_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the configuration subsystem regression with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_cfg_subsys -f cfg_subsys_top.f \
   --Mdir "$BUILD_DIR" -o tb_cfg_subsys
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_cfg_subsys" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
fi

if grep -qx "Regression passed" "$LOG_FILE"; then
   exit 0
fi
exit 1
